// ==== verilog/trap_pkg.sv ====
package trap_pkg;

    // datapath and CSR address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // held trap kind, as seen by the controller
    typedef enum logic [2:0] {
        TRAP_NONE                   = 3'd0,
        TRAP_FENCEI                 = 3'd1,
        TRAP_MRET                   = 3'd2,
        TRAP_ECALL                  = 3'd3,
        TRAP_EBREAK                 = 3'd4,
        TRAP_MISALIGNED_INSTRUCTION = 3'd5,
        TRAP_MISALIGNED_MEMORY      = 3'd6
    } trap_status_t;

    // pre-trap handling states
    // each name tells which step finished in the previous cycle
    typedef enum logic [1:0] {
        PTH_IDLE         = 2'd0,
        PTH_WRITE_MEPC   = 2'd1,
        PTH_WRITE_MCAUSE = 2'd2,
        PTH_READ_MTVEC   = 2'd3
    } pth_state_t;

    // machine-mode CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;

    // mcause exception codes
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED_FETCH = 32'd0;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT       = 32'd3;
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED_LOAD  = 32'd4;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M          = 32'd11;

    // step from mepc to the instruction after it on MRET
    localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

endpackage

// ==== verilog/trap_arbiter.sv ====
`timescale 1ns/1ps

module trap_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ecall,            // ID stage
    input  logic                   ebreak,           // ID stage
    input  logic                   misaligned_fetch, // EX stage
    input  logic                   misaligned_mem,   // MEM stage
    input  logic                   mret,
    input  logic                   fence_i,
    input  logic                   trap_done,
    output trap_pkg::trap_status_t trap_status
);

    trap_pkg::trap_status_t sampled;

    // oldest instruction wins, so the deepest stage comes first
    always_comb begin
        if (misaligned_mem)
            sampled = trap_pkg::TRAP_MISALIGNED_MEMORY;
        else if (misaligned_fetch)
            sampled = trap_pkg::TRAP_MISALIGNED_INSTRUCTION;
        else if (ebreak)
            sampled = trap_pkg::TRAP_EBREAK;
        else if (ecall)
            sampled = trap_pkg::TRAP_ECALL;
        else if (mret)
            sampled = trap_pkg::TRAP_MRET;
        else if (fence_i)
            sampled = trap_pkg::TRAP_FENCEI;
        else
            sampled = trap_pkg::TRAP_NONE;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trap_status <= trap_pkg::TRAP_NONE;
        end else if (trap_status == trap_pkg::TRAP_NONE) begin
            trap_status <= sampled;            // capture a new event
        end else if (trap_done) begin
            trap_status <= trap_pkg::TRAP_NONE; // sequence finished
        end
        // strobes seen while a kind is held are dropped since the pipeline is stalled
    end

    // the controller must see one steady kind through the whole sequence
    a_status_held : assert property (@(posedge clk) disable iff (reset)
        (trap_status != trap_pkg::TRAP_NONE && !trap_done) |=> $stable(trap_status));

endmodule

// ==== verilog/trap_controller.sv ====
`timescale 1ns/1ps

module trap_controller (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [trap_pkg::XLEN-1:0]       id_pc,
    input  logic [trap_pkg::XLEN-1:0]       ex_pc,
    input  logic [trap_pkg::XLEN-1:0]       mem_pc,
    input  trap_pkg::trap_status_t          trap_status,
    input  logic [trap_pkg::XLEN-1:0]       csr_read_data,
    output logic [trap_pkg::XLEN-1:0]       trap_target,   // handler or return address
    output logic                            ic_clean,      // cache flush for FENCE.I
    output logic                            debug_mode,
    output logic                            csr_write_enable,
    output logic                            trap_done,     // low stalls the pc
    output logic [trap_pkg::CSR_ADDR_W-1:0] csr_trap_address,
    output logic [trap_pkg::XLEN-1:0]       csr_trap_write_data
);

    trap_pkg::pth_state_t state;
    trap_pkg::pth_state_t next_state;
    logic                 debug_q;     // debug level carried between cycles
    logic                 multi_cycle;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= trap_pkg::PTH_IDLE;
            debug_q <= 1'b0;
        end else begin
            state   <= next_state;
            debug_q <= debug_mode;
        end
    end

    // kinds that run the pre-trap handling sequence
    always_comb begin
        case (trap_status)
            trap_pkg::TRAP_ECALL,
            trap_pkg::TRAP_EBREAK,
            trap_pkg::TRAP_MISALIGNED_INSTRUCTION,
            trap_pkg::TRAP_MISALIGNED_MEMORY: multi_cycle = 1'b1;
            default:                          multi_cycle = 1'b0;
        endcase
    end

    always_comb begin
        ic_clean            = 1'b0;
        csr_write_enable    = 1'b0;
        csr_trap_address    = '0;
        csr_trap_write_data = '0;
        trap_target         = '0;
        trap_done           = 1'b1;
        next_state          = trap_pkg::PTH_IDLE;
        debug_mode          = debug_q;

        if (!multi_cycle) begin
            // single cycle kinds never touch the state register
            case (trap_status)
                trap_pkg::TRAP_FENCEI: begin
                    ic_clean = 1'b1;
                end
                trap_pkg::TRAP_MRET: begin
                    debug_mode       = 1'b0;
                    csr_trap_address = trap_pkg::CSR_MEPC;
                    // word align the saved pc before stepping past it
                    trap_target = {csr_read_data[trap_pkg::XLEN-1:2], 2'b00}
                                  + trap_pkg::INSN_BYTES;
                end
                default: begin
                    next_state = trap_pkg::PTH_IDLE;
                end
            endcase
        end else begin
            case (state)
                trap_pkg::PTH_IDLE: begin
                    csr_write_enable = 1'b1;
                    csr_trap_address = trap_pkg::CSR_MEPC;
                    case (trap_status)
                        trap_pkg::TRAP_ECALL,
                        trap_pkg::TRAP_EBREAK:            csr_trap_write_data = id_pc;
                        trap_pkg::TRAP_MISALIGNED_MEMORY: csr_trap_write_data = mem_pc;
                        default:                          csr_trap_write_data = ex_pc;
                    endcase
                    trap_done  = 1'b0;
                    next_state = trap_pkg::PTH_WRITE_MEPC;
                end
                trap_pkg::PTH_WRITE_MEPC: begin
                    csr_write_enable = 1'b1;
                    csr_trap_address = trap_pkg::CSR_MCAUSE;
                    case (trap_status)
                        trap_pkg::TRAP_MISALIGNED_MEMORY:
                            csr_trap_write_data = trap_pkg::CAUSE_MISALIGNED_LOAD;
                        trap_pkg::TRAP_MISALIGNED_INSTRUCTION:
                            csr_trap_write_data = trap_pkg::CAUSE_MISALIGNED_FETCH;
                        trap_pkg::TRAP_EBREAK:
                            csr_trap_write_data = trap_pkg::CAUSE_BREAKPOINT;
                        default:
                            csr_trap_write_data = trap_pkg::CAUSE_ECALL_M;
                    endcase
                    trap_done  = 1'b0;
                    next_state = trap_pkg::PTH_WRITE_MCAUSE;
                end
                trap_pkg::PTH_WRITE_MCAUSE: begin
                    if (trap_status == trap_pkg::TRAP_EBREAK) begin
                        debug_mode = 1'b1;                  // enter debug, release stall
                        next_state = trap_pkg::PTH_IDLE;
                    end else begin
                        trap_done  = 1'b0;                  // one idle transfer cycle
                        next_state = trap_pkg::PTH_READ_MTVEC;
                    end
                end
                trap_pkg::PTH_READ_MTVEC: begin
                    csr_trap_address = trap_pkg::CSR_MTVEC;
                    trap_target      = csr_read_data;       // handler base
                    next_state       = trap_pkg::PTH_IDLE;
                end
                default: begin
                    next_state = trap_pkg::PTH_IDLE;
                end
            endcase
        end
    end

    a_flush_no_csr_write : assert property (@(posedge clk) disable iff (reset)
        !(ic_clean && csr_write_enable));

    // only ECALL, EBREAK and misaligned kinds may start the sequence
    a_idle_exit : assert property (@(posedge clk) disable iff (reset)
        (state == trap_pkg::PTH_IDLE && !multi_cycle) |=> state == trap_pkg::PTH_IDLE);

endmodule

// ==== verilog/trap_csr_file.sv ====
`timescale 1ns/1ps

module trap_csr_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            csr_write_enable,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_trap_address,
    input  logic [trap_pkg::XLEN-1:0]       csr_trap_write_data,
    input  logic                            mtvec_write,  // setup load from outside
    input  logic [trap_pkg::XLEN-1:0]       mtvec_data,
    output logic [trap_pkg::XLEN-1:0]       csr_read_data,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] dbg_addr,
    output logic [trap_pkg::XLEN-1:0]       dbg_data
);

    logic [trap_pkg::XLEN-1:0] mepc;
    logic [trap_pkg::XLEN-1:0] mcause;
    logic [trap_pkg::XLEN-1:0] mtvec;

    // controller writes take priority over the external mtvec load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (csr_write_enable) begin
            case (csr_trap_address)
                trap_pkg::CSR_MEPC:   mepc   <= csr_trap_write_data;
                trap_pkg::CSR_MCAUSE: mcause <= csr_trap_write_data;
                trap_pkg::CSR_MTVEC:  mtvec  <= csr_trap_write_data;
                default: ;            // unknown address writes nothing
            endcase
        end else if (mtvec_write) begin
            mtvec <= mtvec_data;
        end
    end

    // shared address decode for both read ports
    function automatic logic [trap_pkg::XLEN-1:0] csr_mux(
        input logic [trap_pkg::CSR_ADDR_W-1:0] addr
    );
        logic [trap_pkg::XLEN-1:0] value;
        case (addr)
            trap_pkg::CSR_MEPC:   value = mepc;
            trap_pkg::CSR_MCAUSE: value = mcause;
            trap_pkg::CSR_MTVEC:  value = mtvec;
            default:              value = '0;  // unimplemented reads as zero
        endcase
        return value;
    endfunction

    always_comb begin
        csr_read_data = csr_mux(csr_trap_address);  // trap port
    end

    always_comb begin
        dbg_data = csr_mux(dbg_addr);               // debug port
    end

endmodule

// ==== verilog/trap_unit_top.sv ====
`timescale 1ns/1ps

module trap_unit_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [trap_pkg::XLEN-1:0]       id_pc,
    input  logic [trap_pkg::XLEN-1:0]       ex_pc,
    input  logic [trap_pkg::XLEN-1:0]       mem_pc,
    input  logic                            ecall,
    input  logic                            ebreak,
    input  logic                            misaligned_fetch,
    input  logic                            misaligned_mem,
    input  logic                            mret,
    input  logic                            fence_i,
    input  logic                            mtvec_write,
    input  logic [trap_pkg::XLEN-1:0]       mtvec_data,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] dbg_addr,
    output logic [trap_pkg::XLEN-1:0]       trap_target,
    output logic                            ic_clean,
    output logic                            debug_mode,
    output logic                            trap_done,
    output logic [trap_pkg::XLEN-1:0]       dbg_data
);

    trap_pkg::trap_status_t          trap_status;
    logic                            csr_write_enable;
    logic [trap_pkg::CSR_ADDR_W-1:0] csr_trap_address;
    logic [trap_pkg::XLEN-1:0]       csr_trap_write_data;
    logic [trap_pkg::XLEN-1:0]       csr_read_data;

    trap_arbiter u_arbiter (
        .clk              (clk),
        .reset            (reset),
        .ecall            (ecall),
        .ebreak           (ebreak),
        .misaligned_fetch (misaligned_fetch),
        .misaligned_mem   (misaligned_mem),
        .mret             (mret),
        .fence_i          (fence_i),
        .trap_done        (trap_done),     // release from the controller
        .trap_status      (trap_status)
    );

    trap_controller u_controller (
        .clk                 (clk),
        .reset               (reset),
        .id_pc               (id_pc),
        .ex_pc               (ex_pc),
        .mem_pc              (mem_pc),
        .trap_status         (trap_status),
        .csr_read_data       (csr_read_data),
        .trap_target         (trap_target),
        .ic_clean            (ic_clean),
        .debug_mode          (debug_mode),
        .csr_write_enable    (csr_write_enable),
        .trap_done           (trap_done),
        .csr_trap_address    (csr_trap_address),
        .csr_trap_write_data (csr_trap_write_data)
    );

    trap_csr_file u_csr_file (
        .clk                 (clk),
        .reset               (reset),
        .csr_write_enable    (csr_write_enable),
        .csr_trap_address    (csr_trap_address),
        .csr_trap_write_data (csr_trap_write_data),
        .mtvec_write         (mtvec_write),
        .mtvec_data          (mtvec_data),
        .csr_read_data       (csr_read_data),
        .dbg_addr            (dbg_addr),
        .dbg_data            (dbg_data)
    );

endmodule

// ==== tb/trap_checker.sv ====
`timescale 1ns/1ps

module trap_checker (
    input logic                      clk,
    input logic [trap_pkg::XLEN-1:0] trap_target,
    input logic                      ic_clean,
    input logic                      debug_mode,
    input logic                      trap_done,
    input logic [trap_pkg::XLEN-1:0] dbg_data
);

    int          pass_count = 0;
    int          fail_count = 0;
    int          test_num = 0;
    int          errors;
    int          stall_cycles;   // cycles with trap_done low
    int          clean_cycles;   // cycles with ic_clean high
    logic        active = 1'b0;
    logic        done_seen;
    logic        timed_out;
    logic [5:0]  strobes;        // ecall, ebreak, fetch, mem, mret, fence_i from bit 0
    logic [31:0] exp_target;
    logic        exp_debug;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // stall length of the winning strobe with the deepest stage first
    function automatic int expected_stall(input logic [5:0] s);
        if (s[3] || s[2])
            return 3;
        if (s[1])
            return 2;   // EBREAK enters debug instead of the mtvec transfer
        if (s[0])
            return 3;
        return 0;
    endfunction

    task automatic begin_test(input int num, input logic [5:0] s,
                              input logic [31:0] target, input logic dbg);
        test_num     = num;
        strobes      = s;
        exp_target   = target;
        exp_debug    = dbg;
        errors       = 0;
        stall_cycles = 0;
        clean_cycles = 0;
        done_seen    = 1'b0;
        timed_out    = 1'b0;
        active       = 1'b1;
    endtask

    task automatic note_timeout();
        timed_out = 1'b1;
    endtask

    task automatic check_csr(input string name, input logic [31:0] expected);
        @(negedge clk);
        compare_value(name, expected, dbg_data);
    endtask

    // first cycle with trap_done high is the done cycle
    always @(negedge clk) begin
        if (active) begin
            if (!trap_done)
                stall_cycles++;
            if (ic_clean)
                clean_cycles++;
            if (trap_done) begin
                if (!done_seen)
                    compare_value("trap_target", exp_target, trap_target);
                compare_value("debug_mode", {31'b0, exp_debug}, {31'b0, debug_mode});
                done_seen = 1'b1;
            end
        end
    end

    task automatic end_test();
        active = 1'b0;
        if (timed_out) begin
            $display("test %0d: timed out waiting for trap_done to rise", test_num);
            fail_count++;
        end else begin
            compare_value("trap_done low cycles", expected_stall(strobes), stall_cycles);
            compare_value("ic_clean high cycles", (strobes == 6'h20) ? 1 : 0, clean_cycles);
            if (errors == 0) begin
                $display("test %0d: ok", test_num);
                pass_count++;
            end else begin
                $display("test %0d: %0d wrong values", test_num, errors);
                fail_count++;
            end
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        fail_count++;
    endtask

    task automatic print_summary();
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
    endtask

endmodule

// ==== tb/tb_trap_unit.sv ====
`timescale 1ns/1ps

module tb_trap_unit;

    logic                            clk = 1'b0;
    logic                            reset;
    logic [trap_pkg::XLEN-1:0]       id_pc;
    logic [trap_pkg::XLEN-1:0]       ex_pc;
    logic [trap_pkg::XLEN-1:0]       mem_pc;
    logic                            ecall;
    logic                            ebreak;
    logic                            misaligned_fetch;
    logic                            misaligned_mem;
    logic                            mret;
    logic                            fence_i;
    logic                            mtvec_write;
    logic [trap_pkg::XLEN-1:0]       mtvec_data;
    logic [trap_pkg::CSR_ADDR_W-1:0] dbg_addr;
    logic [trap_pkg::XLEN-1:0]       trap_target;
    logic                            ic_clean;
    logic                            debug_mode;
    logic                            trap_done;
    logic [trap_pkg::XLEN-1:0]       dbg_data;

    // one file row holds strobes, late strobes, id_pc, ex_pc, mem_pc, mtvec,
    // target, mepc, mcause and debug
    logic [31:0] col [10];
    int          fd;
    int          test_num;

    trap_unit_top uut (.*);

    trap_checker chk (.*);

    always #10 clk = ~clk;

    task automatic drive_strobes(input logic [5:0] s);
        ecall            = s[0];
        ebreak           = s[1];
        misaligned_fetch = s[2];
        misaligned_mem   = s[3];
        mret             = s[4];
        fence_i          = s[5];
    endtask

    task automatic run_test();
        int waited;
        @(posedge clk);
        #2;
        mtvec_write = 1'b1;           // handler base for this test
        mtvec_data  = col[5];
        @(posedge clk);
        #2;
        mtvec_write = 1'b0;
        id_pc       = col[2];
        ex_pc       = col[3];
        mem_pc      = col[4];
        drive_strobes(col[0][5:0]);
        @(posedge clk);               // strobes sampled here
        #2;
        chk.begin_test(test_num, col[0][5:0], col[6], col[9][0]);
        drive_strobes(col[1][5:0]);   // lands while the pc is stalled
        @(posedge clk);
        #2;
        drive_strobes(6'h00);
        waited = 0;
        while (!trap_done && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!trap_done)
            chk.note_timeout();
        dbg_addr = trap_pkg::CSR_MEPC;
        chk.check_csr("mepc", col[7]);
        @(posedge clk);
        #2;
        dbg_addr = trap_pkg::CSR_MCAUSE;
        chk.check_csr("mcause", col[8]);
        @(posedge clk);
        #2;
        chk.end_test();
    endtask

    initial begin
        reset       = 1'b1;
        id_pc       = '0;
        ex_pc       = '0;
        mem_pc      = '0;
        mtvec_write = 1'b0;
        mtvec_data  = '0;
        dbg_addr    = '0;
        drive_strobes(6'h00);
        repeat (8) @(posedge clk);
        #2;
        reset    = 1'b0;
        test_num = 0;
        fd = $fopen("tb/trap_input.txt", "r");
        if (fd == 0) begin
            chk.report_failure("cannot open tb/trap_input.txt");
        end else begin
            while ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h\n", col[0], col[1], col[2],
                           col[3], col[4], col[5], col[6], col[7], col[8], col[9]) == 10) begin
                test_num++;
                run_test();
            end
            $fclose(fd);
        end
        chk.print_summary();
        if (chk.fail_count == 0 && chk.pass_count > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb/trap_input.txt ====
01 00 00001000 00001004 00001008 00008000 00008000 00001000 0000000b 0
20 00 00001010 00001014 00001018 00008000 00000000 00001000 0000000b 0
10 00 00001020 00001024 00001028 00008000 00001004 00001000 0000000b 0
08 00 00002000 00002004 00002008 00008100 00008100 00002008 00000004 0
04 00 00003000 00003006 00003008 00008100 00008100 00003006 00000000 0
0c 00 00004000 00004004 00004008 00008200 00008200 00004008 00000004 0
02 00 00005002 00005004 00005008 00008200 00000000 00005002 00000003 1
10 00 00005010 00005014 00005018 00008200 00005004 00005002 00000003 0
01 02 00006000 00006004 00006008 00009000 00009000 00006000 0000000b 0
20 00 00006010 00006014 00006018 00009000 00000000 00006000 0000000b 0

// ==== tb.f ====
verilog/trap_pkg.sv
verilog/trap_arbiter.sv
verilog/trap_controller.sv
verilog/trap_csr_file.sv
verilog/trap_unit_top.sv
tb/trap_checker.sv
tb/tb_trap_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the trap unit testbench, pass or fail comes from the log
rm -f sim.log \
    && verilator --binary --timing --top-module tb_trap_unit -f tb.f -o sim_trap_unit \
    && ./obj_dir/sim_trap_unit | tee sim.log \
    && grep -q "All tests passed" sim.log \
    || { echo "simulation did not pass"; exit 1; }
